/* verilog/simple_processor_params.svh */
`ifndef SIMPLE_PROCESSOR_PARAMS_SVH
`define SIMPLE_PROCESSOR_PARAMS_SVH

// Register and result width
`define DATA_WIDTH 32
// Raw immediate field from the instruction word
`define IMM_WIDTH 6
// Shift amount, low bits of rs2
`define SHAMT_WIDTH 5
// ALU opcode field
`define OP_WIDTH 4

`endif

/* verilog/simple_processor_pkg.sv */
`include "simple_processor_params.svh"

package simple_processor_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////////////

  // One register value
  typedef logic [`DATA_WIDTH-1:0] data_t;
  // Immediate as it sits in the instruction
  typedef logic [`IMM_WIDTH-1:0] imm_t;
  typedef logic [`SHAMT_WIDTH-1:0] shamt_t;
  typedef logic [`OP_WIDTH-1:0] op_t;

  //////////////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////////////

  // Adder unit
  localparam op_t OP_ADD = op_t'(0);
  localparam op_t OP_SUB = op_t'(1);
  localparam op_t OP_ADDI = op_t'(2);
  localparam op_t OP_SLT = op_t'(3);
  // Bitwise and shift unit
  localparam op_t OP_AND = op_t'(4);
  localparam op_t OP_OR = op_t'(5);
  localparam op_t OP_XOR = op_t'(6);
  localparam op_t OP_SLL = op_t'(7);
  localparam op_t OP_SRL = op_t'(8);
  // Codes 9 to 15 have no owner

  // Owned by alu_math
  function automatic logic op_is_math(input op_t op);
    return op inside {OP_ADD, OP_SUB, OP_ADDI, OP_SLT};
  endfunction

  // Owned by alu_logic
  function automatic logic op_is_logic(input op_t op);
    return op inside {OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};
  endfunction

endpackage

/* verilog/alu_operand_if.sv */
`timescale 1ns/1ps

interface alu_operand_if;
  import simple_processor_pkg::*;

  // Issue strobe, one operation per high cycle
  logic issue_valid;
  op_t op;
  // Register operands
  data_t rs1;
  data_t rs2;
  // Raw immediate, sign extended by the adder unit
  imm_t imm;

  // Top level places the issued operation here
  modport driver (
    output issue_valid, op, rs1, rs2, imm
  );

  // Adder unit needs the immediate as well
  modport math_side (
    input op, rs1, rs2, imm
  );

  modport logic_side (
    input op, rs1, rs2
  );

  // Write-back only sees the strobe and the opcode
  modport wb_side (
    input issue_valid, op
  );

endinterface

/* verilog/alu_math.sv */
`timescale 1ns/1ps
`include "simple_processor_params.svh"

module alu_math (
  alu_operand_if.math_side operand,
  output simple_processor_pkg::data_t math_result
);
  import simple_processor_pkg::*;

  //////////////////////////////////////////////////////////////////////////////
  // Adder operands
  //////////////////////////////////////////////////////////////////////////////

  // Negated rs2 for SUB and SLT
  data_t rs2_twos;
  // Immediate widened to a full register
  data_t imm_ext;
  // Second adder input after the mux
  data_t adder_b;
  data_t sum;
  // Signed compare of rs1 against rs2
  logic sub_overflow;
  logic slt_less;

  // Two's complement of rs2
  assign rs2_twos = ~operand.rs2 + data_t'(1);

  // Replicate bit 5 of the immediate into the upper bits
  assign imm_ext = {{(`DATA_WIDTH-`IMM_WIDTH){operand.imm[`IMM_WIDTH-1]}}, operand.imm};

  // Input mux in front of the shared adder
  always_comb begin
    case (operand.op)
      OP_ADDI: adder_b = imm_ext;
      OP_ADD: adder_b = operand.rs2;
      OP_SUB, OP_SLT: adder_b = rs2_twos;
      // Outside this unit, adder idles
      default: adder_b = '0;
    endcase
  end

  // One adder for all four ops, wraps modulo 2^32
  assign sum = operand.rs1 + adder_b;

  //////////////////////////////////////////////////////////////////////////////
  // Signed less-than
  //////////////////////////////////////////////////////////////////////////////

  // Overflow of rs1 - rs2
  // Operand signs differ and the difference flips away from rs1
  assign sub_overflow = (operand.rs1[`DATA_WIDTH-1] ^ operand.rs2[`DATA_WIDTH-1]) &
                        (operand.rs1[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1]);

  // Sign of the difference, corrected by overflow
  assign slt_less = sum[`DATA_WIDTH-1] ^ sub_overflow;

  // Result select
  always_comb begin
    case (operand.op)
      OP_ADD, OP_SUB, OP_ADDI: math_result = sum;
      OP_SLT: math_result = {{(`DATA_WIDTH-1){1'b0}}, slt_less};
      // Legality is judged in write-back
      default: math_result = '0;
    endcase
  end

endmodule

/* verilog/alu_logic.sv */
`timescale 1ns/1ps
`include "simple_processor_params.svh"

module alu_logic (
  alu_operand_if.logic_side operand,
  output simple_processor_pkg::data_t logic_result
);
  import simple_processor_pkg::*;

  //////////////////////////////////////////////////////////////////////////////
  // Bitwise and shift results
  //////////////////////////////////////////////////////////////////////////////

  // Only the low five bits of rs2 count
  shamt_t shamt;
  data_t and_result;
  data_t or_result;
  data_t xor_result;
  // Logical shifts, zeros shifted in
  data_t sll_result;
  data_t srl_result;

  // rs2 of 33 shifts by 1
  assign shamt = operand.rs2[`SHAMT_WIDTH-1:0];

  // Bitwise ops
  assign and_result = operand.rs1 & operand.rs2;
  assign or_result = operand.rs1 | operand.rs2;
  assign xor_result = operand.rs1 ^ operand.rs2;

  // Shifts of rs1
  assign sll_result = operand.rs1 << shamt;
  assign srl_result = operand.rs1 >> shamt;

  // Pick by opcode
  always_comb begin
    case (operand.op)
      OP_AND: logic_result = and_result;
      OP_OR: logic_result = or_result;
      OP_XOR: logic_result = xor_result;
      OP_SLL: logic_result = sll_result;
      OP_SRL: logic_result = srl_result;
      // Not ours
      default: logic_result = '0;
    endcase
  end

endmodule

/* verilog/alu_writeback.sv */
`timescale 1ns/1ps

module alu_writeback (
  input logic clk,
  input logic reset,
  alu_operand_if.wb_side operand,
  input simple_processor_pkg::data_t math_result,
  input simple_processor_pkg::data_t logic_result,
  output logic result_valid,
  output simple_processor_pkg::data_t result,
  output logic illegal_op
);
  import simple_processor_pkg::*;

  //////////////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////////////

  // Owner of the current opcode
  logic is_math;
  logic is_logic;
  // Next register values
  data_t sel_result;
  logic sel_illegal;

  assign is_math = op_is_math(operand.op);
  assign is_logic = op_is_logic(operand.op);

  always_comb begin
    sel_result = '0;
    sel_illegal = 1'b0;
    if (is_math) begin
      sel_result = math_result;
    end else if (is_logic) begin
      sel_result = logic_result;
    end else begin
      // No unit owns codes 9 to 15, force zero
      sel_illegal = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////////////

  // Valid follows the strobe by one cycle
  // Result and flag hold between issues
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      result <= '0;
      illegal_op <= 1'b0;
    end else begin
      result_valid <= operand.issue_valid;
      if (operand.issue_valid) begin
        result <= sel_result;
        illegal_op <= sel_illegal;
      end
    end
  end

endmodule

/* verilog/simple_alu.sv */
`timescale 1ns/1ps

module simple_alu (
  input logic clk,
  input logic reset,
  // Issue side
  input logic issue_valid,
  input simple_processor_pkg::op_t op,
  input simple_processor_pkg::data_t rs1,
  input simple_processor_pkg::data_t rs2,
  input simple_processor_pkg::imm_t imm,
  // Write-back side, one cycle after issue
  output logic result_valid,
  output simple_processor_pkg::data_t result,
  output logic illegal_op
);

  //////////////////////////////////////////////////////////////////////////////
  // Issued operation
  //////////////////////////////////////////////////////////////////////////////

  // Shared by all three units
  alu_operand_if u_operand ();

  // Plain ports onto the bundle
  assign u_operand.issue_valid = issue_valid;
  assign u_operand.op = op;
  assign u_operand.rs1 = rs1;
  assign u_operand.rs2 = rs2;
  assign u_operand.imm = imm;

  //////////////////////////////////////////////////////////////////////////////
  // Execute units
  //////////////////////////////////////////////////////////////////////////////

  // Unit outputs, both combinational
  simple_processor_pkg::data_t math_result;
  simple_processor_pkg::data_t logic_result;

  // ADD, SUB, ADDI, SLT
  alu_math u_math (
    .operand (u_operand.math_side),
    .math_result (math_result)
  );

  // AND, OR, XOR, SLL, SRL
  alu_logic u_logic (
    .operand (u_operand.logic_side),
    .logic_result (logic_result)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Write-back
  //////////////////////////////////////////////////////////////////////////////

  // Select, flag and register
  alu_writeback u_writeback (
    .clk (clk),
    .reset (reset),
    .operand (u_operand.wb_side),
    .math_result (math_result),
    .logic_result (logic_result),
    .result_valid (result_valid),
    .result (result),
    .illegal_op (illegal_op)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Synchronous reset held for 10 rising edges
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* verification/simple_alu_checker.sv */
`timescale 1ns/1ps

module simple_alu_checker (
  input logic clk,
  input logic reset,
  input logic issue_valid,
  input logic result_valid,
  input simple_processor_pkg::data_t result,
  input logic illegal_op
);

  ////////////////////////////////////////////////////////////////////////////
  // Write-back rules
  ////////////////////////////////////////////////////////////////////////////

  // One result per issue, exactly one cycle later
  a_valid_follows_issue: assert property (@(posedge clk) disable iff (reset)
    result_valid == $past(issue_valid))
    else $error("result_valid does not follow issue_valid by one cycle");

  // Flag only changes along with a new result
  a_illegal_with_valid: assert property (@(posedge clk) disable iff (reset)
    $changed(illegal_op) |-> result_valid)
    else $error("illegal_op changed without result_valid");

  // Unowned opcodes give zero
  a_illegal_zero: assert property (@(posedge clk) disable iff (reset)
    illegal_op |-> (result == '0))
    else $error("result not zero while illegal_op is high");

  a_result_known: assert property (@(posedge clk) disable iff (reset)
    result_valid |-> !$isunknown(result))
    else $error("result has unknown bits while result_valid is high");

endmodule

/* verification/simple_alu_tb.sv */
`timescale 1ns/1ps
`include "simple_processor_params.svh"

module simple_alu_tb;
  import simple_processor_pkg::*;

  // One directed entry with its expected outcome
  typedef struct packed {
    op_t op;
    data_t rs1;
    data_t rs2;
    imm_t imm;
    data_t exp_result;
    logic exp_illegal;
  } vector_t;

  logic clk;
  logic reset;
  logic issue_valid;
  op_t op;
  data_t rs1;
  data_t rs2;
  imm_t imm;
  logic result_valid;
  data_t result;
  logic illegal_op;

  vector_t table_q[$];
  // Expected {illegal, result} of random ops, oldest first
  logic [`DATA_WIDTH:0] expect_q[$];
  logic issue_prev;
  logic random_done;

  tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

  simple_alu u_dut (
    .clk (clk),
    .reset (reset),
    .issue_valid (issue_valid),
    .op (op),
    .rs1 (rs1),
    .rs2 (rs2),
    .imm (imm),
    .result_valid (result_valid),
    .result (result),
    .illegal_op (illegal_op)
  );

  bind simple_alu simple_alu_checker u_checker (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Opcode rules, returns {illegal, result}
  function automatic logic [`DATA_WIDTH:0] model_op(input op_t o, input data_t a,
                                                     input data_t b, input imm_t i);
    data_t imm_ext;
    imm_ext = data_t'($signed(i));
    case (o)
      OP_ADD: return {1'b0, data_t'(a + b)};
      OP_SUB: return {1'b0, data_t'(a - b)};
      OP_ADDI: return {1'b0, data_t'(a + imm_ext)};
      OP_SLT: return {1'b0, data_t'($signed(a) < $signed(b))};
      OP_AND: return {1'b0, a & b};
      OP_OR: return {1'b0, a | b};
      OP_XOR: return {1'b0, a ^ b};
      OP_SLL: return {1'b0, a << b[`SHAMT_WIDTH-1:0]};
      OP_SRL: return {1'b0, a >> b[`SHAMT_WIDTH-1:0]};
      default: return {1'b1, {`DATA_WIDTH{1'b0}}};
    endcase
  endfunction

  task automatic check_value(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("Mismatch on %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Verification failed");
      $fatal(1, "Stopped at the first wrong value");
    end
  endtask

  // Bounded wait, returns on the negedge that shows the result
  task automatic wait_result();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!result_valid && cycles < 4);
    if (!result_valid) begin
      $display("No result_valid within 4 cycles of waiting");
      $display("Verification failed");
      $fatal(1, "Timed out waiting for a result");
    end
  endtask

  task automatic add_vector(input op_t o, input data_t a, input data_t b, input imm_t i,
                            input data_t r, input logic ill);
    table_q.push_back(vector_t'{o, a, b, i, r, ill});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Phases
  ////////////////////////////////////////////////////////////////////////////

  // Outputs stay zero through reset and the first idle cycle after it
  task automatic check_reset();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      check_value("result_valid", data_t'(result_valid), '0);
      check_value("illegal_op", data_t'(illegal_op), '0);
      check_value("result", result, '0);
    end while (reset && cycles < 20);
    if (reset) begin
      $display("Reset still asserted after 20 cycles");
      $display("Verification failed");
      $fatal(1, "Reset never released");
    end
    // First clock edge with reset low and nothing issued
    @(negedge clk);
    check_value("result_valid", data_t'(result_valid), '0);
    check_value("illegal_op", data_t'(illegal_op), '0);
    check_value("result", result, '0);
  endtask

  // Single issue, result one cycle later, then an idle cycle
  task automatic run_vector(input vector_t v);
    @(posedge clk);
    issue_valid <= 1'b1;
    op <= v.op;
    rs1 <= v.rs1;
    rs2 <= v.rs2;
    imm <= v.imm;
    @(posedge clk);
    issue_valid <= 1'b0;
    wait_result();
    check_value("result", result, v.exp_result);
    check_value("illegal_op", data_t'(illegal_op), data_t'(v.exp_illegal));
    @(negedge clk);
    check_value("result_valid", data_t'(result_valid), '0);
  endtask

  // Random ops, gaps of 0 to 2 idle cycles
  task automatic drive_random(input int count);
    int n;
    int gap;
    op_t o;
    data_t a;
    data_t b;
    imm_t i;
    for (n = 0; n < count; n++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(posedge clk);
        issue_valid <= 1'b0;
      end
      // Roughly one in four is illegal
      if ($urandom_range(0, 3) == 0) o = op_t'($urandom_range(9, 15));
      else o = op_t'($urandom_range(0, 8));
      a = $urandom();
      b = $urandom();
      i = imm_t'($urandom());
      @(posedge clk);
      issue_valid <= 1'b1;
      op <= o;
      rs1 <= a;
      rs2 <= b;
      imm <= i;
      expect_q.push_back(model_op(o, a, b, i));
    end
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic check_random(input int count);
    int n;
    logic [`DATA_WIDTH:0] exp;
    for (n = 0; n < count; n++) begin
      wait_result();
      exp = expect_q.pop_front();
      check_value("result", result, exp[`DATA_WIDTH-1:0]);
      check_value("illegal_op", data_t'(illegal_op), data_t'(exp[`DATA_WIDTH]));
    end
    random_done = 1'b1;
  endtask

  // result_valid mirrors the issue seen one cycle earlier
  task automatic track_strobe();
    while (!random_done) begin
      @(negedge clk);
      check_value("result_valid", data_t'(result_valid), data_t'(issue_prev));
      issue_prev = issue_valid;
    end
  endtask

  initial begin
    int c;
    issue_valid = 1'b0;
    op = OP_ADD;
    rs1 = '0;
    rs2 = '0;
    imm = '0;
    issue_prev = 1'b0;
    random_done = 1'b0;
    void'($urandom(32'h5c88_25f3));

    // Wrap, sign extension, signed compare with overflow
    add_vector(OP_ADD, 32'hFFFF_FFFF, 32'h1, 6'h00, 32'h0, 1'b0);
    add_vector(OP_ADD, 32'h5, 32'h7, 6'h00, 32'hC, 1'b0);
    add_vector(OP_SUB, 32'h0, 32'h1, 6'h00, 32'hFFFF_FFFF, 1'b0);
    add_vector(OP_SUB, 32'hA, 32'h3, 6'h00, 32'h7, 1'b0);
    add_vector(OP_ADDI, 32'h100, 32'h0, 6'h20, 32'hE0, 1'b0);
    add_vector(OP_ADDI, 32'h1, 32'h0, 6'h1F, 32'h20, 1'b0);
    add_vector(OP_SLT, 32'h8000_0000, 32'h1, 6'h00, 32'h1, 1'b0);
    add_vector(OP_SLT, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 6'h00, 32'h0, 1'b0);
    add_vector(OP_SLT, 32'h3, 32'h3, 6'h00, 32'h0, 1'b0);
    // Bitwise, then shifts by rs2 modulo 32
    add_vector(OP_AND, 32'hF0F0_F0F0, 32'hFF00_FF00, 6'h00, 32'hF000_F000, 1'b0);
    add_vector(OP_OR, 32'h0F0F_0000, 32'h0000_00F0, 6'h00, 32'h0F0F_00F0, 1'b0);
    add_vector(OP_XOR, 32'hAAAA_AAAA, 32'hFFFF_0000, 6'h00, 32'h5555_AAAA, 1'b0);
    add_vector(OP_SLL, 32'h8000_0001, 32'd33, 6'h00, 32'h2, 1'b0);
    add_vector(OP_SRL, 32'h8000_0000, 32'd33, 6'h00, 32'h4000_0000, 1'b0);
    add_vector(OP_SLL, 32'h1, 32'd31, 6'h00, 32'h8000_0000, 1'b0);
    // Every unowned code
    for (c = 9; c < 16; c++) begin
      add_vector(op_t'(c), 32'h1234_5678, 32'h9, 6'h3F, 32'h0, 1'b1);
    end

    check_reset();
    foreach (table_q[k]) begin
      run_vector(table_q[k]);
    end

    fork
      drive_random(200);
      check_random(200);
      track_strobe();
    join

    $display("Verification passed");
    $finish;
  end

endmodule

/* simple_alu.f */
+incdir+verilog
verilog/simple_processor_pkg.sv
verilog/alu_operand_if.sv
verilog/alu_math.sv
verilog/alu_logic.sv
verilog/alu_writeback.sv
verilog/simple_alu.sv
verification/tb_clock_gen.sv
verification/simple_alu_checker.sv
verification/simple_alu_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = simple_alu_tb
FILELIST = simple_alu.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
